/* decodeStage.f */
verilog/decodePkg.sv
verilog/resultBus.sv
verilog/idReg.sv
verilog/regFile.sv
verilog/operandBypass.sv
verilog/instrDecoder.sv
verilog/loadUseHazard.sv
verilog/decodeStage.sv
test/clockGen.sv
test/decodeStage_properties.sv
test/decodeStageTb.sv

/* test/clockGen.sv */
// ========================================
// clockGen
// free-running testbench clock, period 4
// ========================================
module clockGen (
    output logic clk
);

    initial clk = 1'b0;

    always #2 clk = ~clk;  // half period

endmodule

/* test/decodeStageTb.sv */
// ========================================
// decodeStageTb
// table-driven testbench for the decode stage,
// one table row loaded and checked per clock
// ========================================
module decodeStageTb import decodePkg::*; ();

    localparam int NROWS   = 25;
    localparam int TIMEOUT = NROWS * 4 + 100;

    typedef struct {
        instrWord   instr;
        word        pc, tgt;
        logic [2:0] strb;   // idWr, idFlush, idDisWr
        logic [3:0] we;     // exe, mem, mem2, wb
        logic [19:0] dsts;  // exe, mem, mem2, wb destinations
        logic [2:0] mr;     // exe, mem, mem2 memRead
        word        opA, opB;
        logic [8:0] dec;    // aluOp, branch, isJump, regWrite, memRead, memWrite
        regIdx      dst;
        word        imm, jAddr, bAddr, pc8;
        logic [1:0] pred;   // jSuccess, pc8Success
        logic [2:0] stall;
        logic [2:0] chk;    // operands, decode, addresses
    } rowT;

    rowT rows [NROWS];
    int  errors = 0;
    int  checks = 0;
    int  curRow;

    logic     clk, rstN, idWr, idFlush, idDisWr;
    instrWord ifInstr;
    word      ifPc, ifTarget;
    logic     exeRegWrite, memRegWrite, mem2RegWrite, wbRegWrite;
    regIdx    exeDst, memDst, mem2Dst, wbDst;
    word      exeResult, memResult, mem2Result, wbResult;
    logic     exeMemRead, memMemRead, mem2MemRead;
    word      opA, opB, imm, jumpAddr, branchAddr, pcAdd8;
    aluOpT    aluOp;
    branchT   branch;
    regIdx    dst;
    logic     isJump, regWrite, memRead, memWrite, jSuccess, pc8Success;
    logic     exStall, mem1Stall, mem2Stall;

    clockGen clockGen_i (.clk);

    decodeStage decodeStage_i (.*);

    // stage tag in the top nibble, row and destination in the low bits
    function automatic word stageValue(input logic [3:0] tag, input int row, input regIdx d);
        return {tag, 12'h000, 8'(row), 3'b000, d};
    endfunction

    task automatic checkVal(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: row %0d %s got %h expected %h",
                     $time, curRow, what, got, exp);
        end
    endtask

    task automatic fillTable();
        for (int i = 0; i < 4; i++) begin  // WB fills r1..r4, NOP in decode
            rows[i] = '{0, 0, 0, 3'b100, 4'b0001, 20'(i + 1), 3'b000,
                0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b110};
        end
        rows[4]  = '{'h00222821, 0, 0, 3'b100, 4'b0000, 20'h0, 3'b000,  // addu r5,r1,r2
            'hB0000001, 'hB0000102, {ALU_ADD, BR_NONE, 4'b0100}, 5, 'h2821, 0, 0, 0, 0, 0, 3'b110};
        rows[5]  = '{'h00643023, 0, 0, 3'b100, 4'b0000, 20'h0, 3'b000,  // subu r6,r3,r4
            'hB0000203, 'hB0000304, {ALU_SUB, BR_NONE, 4'b0100}, 6, 'h3023, 0, 0, 0, 0, 0, 3'b110};
        rows[6]  = '{'h00013824, 0, 0, 3'b100, 4'b0001, 20'h0, 3'b000,  // and, WB to r0
            0, 'hB0000001, {ALU_AND, BR_NONE, 4'b0100}, 7, 'h3824, 0, 0, 0, 0, 0, 3'b110};
        rows[7]  = '{'h00224025, 0, 0, 3'b100, 4'b1111, 20'h08421, 3'b000,  // all stages hit r1
            'hE0000701, 'hB0000102, {ALU_OR, BR_NONE, 4'b0100}, 8, 'h4025, 0, 0, 0, 0, 0, 3'b110};
        rows[8]  = '{'h00224025, 0, 0, 3'b100, 4'b0111, 20'h08421, 3'b000,
            'hD0000801, 'hB0000102, 0, 0, 0, 0, 0, 0, 0, 0, 3'b100};
        rows[9]  = '{'h00224025, 0, 0, 3'b100, 4'b0011, 20'h08421, 3'b000,  // mem enable low
            'hC0000901, 'hB0000102, 0, 0, 0, 0, 0, 0, 0, 0, 3'b100};
        rows[10] = '{'h00224025, 0, 0, 3'b100, 4'b0101, 20'h10802, 3'b000,  // rt, mem over wb
            'hB0000901, 'hD0000A02, 0, 0, 0, 0, 0, 0, 0, 0, 3'b100};
        rows[11] = '{'h0022482A, 0, 0, 3'b100, 4'b0000, 20'h0, 3'b000,
            'hB0000901, 'hB0000A02, {ALU_SLT, BR_NONE, 4'b0100}, 9, 'h482A, 0, 0, 0, 0, 0, 3'b110};
        rows[12] = '{'h242AFFFC, 0, 0, 3'b100, 4'b0000, 20'h0, 3'b000,  // addiu -4
            'hB0000901, 0, {ALU_ADD, BR_NONE, 4'b0100}, 10, 'hFFFFFFFC, 0, 0, 0, 0, 0, 3'b110};
        rows[13] = '{'h340B8001, 0, 0, 3'b100, 4'b0000, 20'h0, 3'b000,  // ori, zero extended
            0, 0, {ALU_OR, BR_NONE, 4'b0100}, 11, 'h8001, 0, 0, 0, 0, 0, 3'b010};
        rows[14] = '{'h300CF0F0, 0, 0, 3'b100, 4'b0000, 20'h0, 3'b111,  // loads to r0, andi reads r0
            0, 0, {ALU_AND, BR_NONE, 4'b0100}, 12, 'hF0F0, 0, 0, 0, 0, 0, 3'b010};
        rows[15] = '{'h3C0D1234, 0, 0, 3'b100, 4'b0000, 20'h68000, 3'b100,  // lui ignores rt
            0, 0, {ALU_LUI, BR_NONE, 4'b0100}, 13, 'h1234, 0, 0, 0, 0, 0, 3'b010};
        rows[16] = '{'h8C6E0008, 0, 0, 3'b100, 4'b0000, 20'h18000, 3'b100,
            0, 0, {ALU_ADD, BR_NONE, 4'b0110}, 14, 8, 0, 0, 0, 0, 3'b100, 3'b010};
        rows[17] = '{'hAC64FFF8, 0, 0, 3'b100, 4'b0000, 20'h01000, 3'b011,  // mem2 dst is r0
            0, 0, {ALU_ADD, BR_NONE, 4'b0001}, 4, 'hFFFFFFF8, 0, 0, 0, 0, 3'b010, 3'b010};
        rows[18] = '{'h10220003, 'h100, 'h110, 3'b100, 4'b0000, 20'h00040, 3'b001,
            0, 0, {ALU_SUB, BR_BEQ, 4'b0000}, 2, 3,
            'h0088000C, 'h110, 'h108, 2'b00, 3'b001, 3'b011};
        rows[19] = '{'h1422FFFE, 'h2000, 'h2008, 3'b100, 4'b0000, 20'h0, 3'b000,
            0, 0, {ALU_SUB, BR_BNE, 4'b0000}, 2, 'hFFFFFFFE,
            'h008BFFF8, 'h1FFC, 'h2008, 2'b01, 0, 3'b011};
        rows[20] = '{'h08100040, 'h30000000, 'h30400100, 3'b100, 4'b0000, 20'h0, 3'b000,
            0, 0, {ALU_ADD, BR_NONE, 4'b1000}, 16, 'h40,
            'h30400100, 'h30000104, 'h30000008, 2'b10, 0, 3'b011};
        rows[21] = '{'h0C000010, 'h0FFFFFFC, 'h12345678, 3'b100, 4'b0000, 20'h0, 3'b000,
            0, 0, {ALU_ADD, BR_NONE, 4'b1100}, 31, 'h10,
            'h10000040, 'h10000040, 'h10000004, 2'b00, 0, 3'b011};
        rows[22] = '{'hFFFFFFFF, 'h44, 'h44, 3'b000, 4'b0000, 20'h0, 3'b000,  // hold jal
            0, 0, {ALU_ADD, BR_NONE, 4'b1100}, 31, 'h10,
            'h10000040, 'h10000040, 'h10000004, 2'b00, 0, 3'b011};
        rows[23] = '{'h00222821, 'h500, 'h500, 3'b110, 4'b0000, 20'h0, 3'b000,  // flush wins
            0, 0, 0, 0, 0, 0, 4, 8, 2'b10, 0, 3'b111};
        rows[24] = '{'h8C6E0008, 0, 0, 3'b101, 4'b0000, 20'h0, 3'b000,  // lw under idDisWr
            'hB0000203, 0, {ALU_ADD, BR_NONE, 4'b0000}, 14, 8, 0, 0, 0, 0, 0, 3'b110};
    endtask

    task automatic driveFetch(input int idx);
        ifInstr  = rows[idx].instr;
        ifPc     = rows[idx].pc;
        ifTarget = rows[idx].tgt;
        {idWr, idFlush} = rows[idx].strb[2:1];
    endtask

    task automatic driveResults(input int idx);
        {exeRegWrite, memRegWrite, mem2RegWrite, wbRegWrite} = rows[idx].we;
        {exeDst, memDst, mem2Dst, wbDst} = rows[idx].dsts;
        exeResult  = stageValue(4'hE, idx, exeDst);
        memResult  = stageValue(4'hD, idx, memDst);
        mem2Result = stageValue(4'hC, idx, mem2Dst);
        wbResult   = stageValue(4'hB, idx, wbDst);
        {exeMemRead, memMemRead, mem2MemRead} = rows[idx].mr;
        idDisWr = rows[idx].strb[0];
    endtask

    task automatic checkRow(input int idx);
        curRow = idx;
        if (rows[idx].chk[2]) begin
            checkVal("opA", opA, rows[idx].opA);
            checkVal("opB", opB, rows[idx].opB);
        end
        if (rows[idx].chk[1]) begin
            checkVal("controls", {aluOp, branch, isJump, regWrite, memRead, memWrite},
                     rows[idx].dec);
            checkVal("dst", dst, rows[idx].dst);
            checkVal("imm", imm, rows[idx].imm);
        end
        if (rows[idx].chk[0]) begin
            checkVal("jumpAddr", jumpAddr, rows[idx].jAddr);
            checkVal("branchAddr", branchAddr, rows[idx].bAddr);
            checkVal("pcAdd8", pcAdd8, rows[idx].pc8);
            checkVal("prediction", {jSuccess, pc8Success}, rows[idx].pred);
        end
        checkVal("stalls", {exStall, mem1Stall, mem2Stall}, rows[idx].stall);
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: table did not complete within %0d time units", TIMEOUT);
        $display("Test failures found");
        $finish;
    end

    initial begin
        {rstN, idWr, idFlush, idDisWr, ifInstr, ifPc, ifTarget} = '0;
        {exeRegWrite, memRegWrite, mem2RegWrite, wbRegWrite} = '0;
        {exeDst, memDst, mem2Dst, wbDst} = '0;
        {exeResult, memResult, mem2Result, wbResult} = '0;
        {exeMemRead, memMemRead, mem2MemRead} = '0;
        fillTable();
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;
        // row k loads at the next edge while row k-1 is checked against its stage results
        for (int k = 0; k <= NROWS; k++) begin
            @(posedge clk);
            #1;
            if (k < NROWS)
                driveFetch(k);
            else
                {idWr, idFlush} = 2'b00;
            if (k > 0)
                driveResults(k - 1);
            #2;
            if (k > 0)
                checkRow(k - 1);
        end
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 decodeStage_i.decodeStage_props_i.assertFails);
        if (errors == 0 && decodeStage_i.decodeStage_props_i.assertFails == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* test/decodeStage_properties.sv */
// ========================================
// decodeStage_properties
// concurrent checks on the decode stage top,
// bound into every decodeStage instance
// ========================================
module decodeStage_properties import decodePkg::*; (
    input logic  clk,
    input logic  rstN,
    input logic  idDisWr,
    input logic  regWrite,
    input logic  memRead,
    input logic  memWrite,
    input regIdx rs,
    input regIdx rt,
    input word   opA,
    input word   opB,
    input logic  exeRegWrite,
    input regIdx exeDst,
    input word   exeResult,
    input logic  exeMemRead,
    input logic  memMemRead,
    input logic  mem2MemRead,
    input logic  exStall,
    input logic  mem1Stall,
    input logic  mem2Stall
);

    int assertFails = 0;

    // EXE match wins, so no older stage can slip into the operand
    fwdOneA: assert property (@(posedge clk) disable iff (!rstN)
        (rs != '0 && exeRegWrite && exeDst == rs) |-> opA == exeResult)
        else begin
            assertFails++;
            $error("operand A took a source other than the matching EXE result");
        end
    fwdOneB: assert property (@(posedge clk) disable iff (!rstN)
        (rt != '0 && exeRegWrite && exeDst == rt) |-> opB == exeResult)
        else begin
            assertFails++;
            $error("operand B took a source other than the matching EXE result");
        end

    noLoadNoStall: assert property (@(posedge clk) disable iff (!rstN)
        !(exeMemRead || memMemRead || mem2MemRead) |-> !(exStall || mem1Stall || mem2Stall))
        else begin
            assertFails++;
            $error("stall raised with no load pending");
        end

    disWrMasks: assert property (@(posedge clk) disable iff (!rstN)
        idDisWr |-> !regWrite && !memRead && !memWrite)
        else begin
            assertFails++;
            $error("side effect enabled while idDisWr is high");
        end

endmodule

bind decodeStage decodeStage_properties decodeStage_props_i (.*);

/* verilog/decodePkg.sv */
// ======================================
// decodePkg
// word types, MIPS opcode and function codes,
// and the decode stage enums
// ======================================
package decodePkg;

    typedef logic [31:0] word;
    typedef logic [4:0]  regIdx;
    typedef logic [31:0] instrWord;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} aluOpT;
    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE} branchT;
    typedef enum logic [2:0] {FWD_RF, FWD_EXE, FWD_MEM, FWD_MEM2, FWD_WB} fwdSel;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type function field, instr[5:0]
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    localparam regIdx LINK_REG = 5'd31;  // $ra

endpackage

/* verilog/decodeStage.sv */
// ======================================
// decodeStage
// ID stage top, stage register, GPRs,
// bypass, decode and load-use detection
// ======================================
module decodeStage import decodePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     idWr,
    input  logic     idFlush,
    input  logic     idDisWr,
    input  instrWord ifInstr,
    input  word      ifPc,
    input  word      ifTarget,
    input  logic     exeRegWrite,
    input  regIdx    exeDst,
    input  word      exeResult,
    input  logic     memRegWrite,
    input  regIdx    memDst,
    input  word      memResult,
    input  logic     mem2RegWrite,
    input  regIdx    mem2Dst,
    input  word      mem2Result,
    input  logic     wbRegWrite,
    input  regIdx    wbDst,
    input  word      wbResult,
    input  logic     exeMemRead,
    input  logic     memMemRead,
    input  logic     mem2MemRead,
    output word      opA,
    output word      opB,
    output aluOpT    aluOp,
    output branchT   branch,
    output logic     isJump,
    output logic     regWrite,
    output logic     memRead,
    output logic     memWrite,
    output regIdx    dst,
    output word      imm,
    output word      jumpAddr,
    output word      branchAddr,
    output word      pcAdd8,
    output logic     jSuccess,
    output logic     pc8Success,
    output logic     exStall,
    output logic     mem1Stall,
    output logic     mem2Stall
);

    instrWord instr;
    word      pc, predTarget, rfA, rfB;
    regIdx    rs, rt;
    logic     readsRs, readsRt;

    resultBus stageRes();

    assign stageRes.exeRegWrite  = exeRegWrite;
    assign stageRes.exeDst       = exeDst;
    assign stageRes.exeResult    = exeResult;
    assign stageRes.memRegWrite  = memRegWrite;
    assign stageRes.memDst       = memDst;
    assign stageRes.memResult    = memResult;
    assign stageRes.mem2RegWrite = mem2RegWrite;
    assign stageRes.mem2Dst      = mem2Dst;
    assign stageRes.mem2Result   = mem2Result;
    assign stageRes.wbRegWrite   = wbRegWrite;
    assign stageRes.wbDst        = wbDst;
    assign stageRes.wbResult     = wbResult;
    assign stageRes.exeMemRead   = exeMemRead;
    assign stageRes.memMemRead   = memMemRead;
    assign stageRes.mem2MemRead  = mem2MemRead;

    assign rs = instr[25:21];
    assign rt = instr[20:16];

    idReg idReg_i (
        .clk, .rstN, .idWr, .idFlush, .ifInstr, .ifPc, .ifTarget,
        .instr, .pc, .predTarget
    );

    regFile regFile_i (
        .clk, .rstN,
        .wrEn   (wbRegWrite),  // WB port only
        .wrDst  (wbDst),
        .wrData (wbResult),
        .rs, .rt,
        .busA   (rfA),
        .busB   (rfB)
    );

    operandBypass operandBypass_i (
        .rs, .rt, .rfA, .rfB,
        .res (stageRes.fwd),
        .opA, .opB
    );

    instrDecoder instrDecoder_i (
        .instr, .pc, .predTarget,
        .disWr (idDisWr),
        .aluOp, .branch, .isJump, .regWrite, .memRead, .memWrite, .dst,
        .readsRs, .readsRt, .imm, .jumpAddr, .branchAddr, .pcAdd8,
        .jSuccess, .pc8Success
    );

    loadUseHazard loadUseHazard_i (
        .rs, .rt, .readsRs, .readsRt,
        .res (stageRes.haz),
        .exStall, .mem1Stall, .mem2Stall
    );

endmodule

/* verilog/idReg.sv */
// ======================================
// idReg
// IF/ID stage register, load, hold or
// flush to a NOP
// ======================================
module idReg import decodePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     idWr,
    input  logic     idFlush,
    input  instrWord ifInstr,
    input  word      ifPc,
    input  word      ifTarget,
    output instrWord instr,
    output word      pc,
    output word      predTarget
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instr      <= '0;
            pc         <= '0;
            predTarget <= '0;
        end else if (idFlush) begin  // flush wins over write
            instr      <= '0;
            pc         <= '0;
            predTarget <= '0;
        end else if (idWr) begin
            instr      <= ifInstr;
            pc         <= ifPc;
            predTarget <= ifTarget;
        end
    end

endmodule

/* verilog/instrDecoder.sv */
// ======================================
// instrDecoder
// control decode, immediate extension,
// jump/branch targets and prediction check
// ======================================
module instrDecoder import decodePkg::*; (
    input  instrWord instr,
    input  word      pc,
    input  word      predTarget,
    input  logic     disWr,
    output aluOpT    aluOp,
    output branchT   branch,
    output logic     isJump,
    output logic     regWrite,
    output logic     memRead,
    output logic     memWrite,
    output regIdx    dst,
    output logic     readsRs,
    output logic     readsRt,
    output word      imm,
    output word      jumpAddr,
    output word      branchAddr,
    output word      pcAdd8,
    output logic     jSuccess,
    output logic     pc8Success
);

    logic [5:0] opcode, funct;
    logic       rfWr, ldRd, stWr;  // raw controls before disWr masking
    logic       zeroExt;
    word        signImm, pcAdd4;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        aluOp   = ALU_ADD;
        branch  = BR_NONE;
        isJump  = 1'b0;
        rfWr    = 1'b0;
        ldRd    = 1'b0;
        stWr    = 1'b0;
        readsRs = 1'b0;
        readsRt = 1'b0;
        zeroExt = 1'b0;
        dst     = instr[20:16];  // rt by default
        case (opcode)
            OP_RTYPE: begin
                dst = instr[15:11];
                case (funct)
                    FN_ADDU: {aluOp, rfWr, readsRs, readsRt} = {ALU_ADD, 3'b111};
                    FN_SUBU: {aluOp, rfWr, readsRs, readsRt} = {ALU_SUB, 3'b111};
                    FN_AND:  {aluOp, rfWr, readsRs, readsRt} = {ALU_AND, 3'b111};
                    FN_OR:   {aluOp, rfWr, readsRs, readsRt} = {ALU_OR, 3'b111};
                    FN_SLT:  {aluOp, rfWr, readsRs, readsRt} = {ALU_SLT, 3'b111};
                    default: ;  // unknown funct stays a NOP
                endcase
            end
            OP_ADDIU: {aluOp, rfWr, readsRs} = {ALU_ADD, 2'b11};
            OP_ANDI:  {aluOp, rfWr, readsRs, zeroExt} = {ALU_AND, 3'b111};
            OP_ORI:   {aluOp, rfWr, readsRs, zeroExt} = {ALU_OR, 3'b111};
            OP_LUI:   {aluOp, rfWr} = {ALU_LUI, 1'b1};
            OP_LW:    {rfWr, ldRd, readsRs} = 3'b111;
            OP_SW:    {stWr, readsRs, readsRt} = 3'b111;
            OP_BEQ:   {aluOp, branch, readsRs, readsRt} = {ALU_SUB, BR_BEQ, 2'b11};
            OP_BNE:   {aluOp, branch, readsRs, readsRt} = {ALU_SUB, BR_BNE, 2'b11};
            OP_J:     isJump = 1'b1;
            OP_JAL: begin
                isJump = 1'b1;
                rfWr   = 1'b1;
                dst    = LINK_REG;
            end
            default: ;  // unknown opcode decodes as a NOP
        endcase
    end

    // disWr squashes side effects only
    assign regWrite = rfWr && !disWr;
    assign memRead  = ldRd && !disWr;
    assign memWrite = stWr && !disWr;

    assign signImm = {{16{instr[15]}}, instr[15:0]};
    assign imm     = zeroExt ? {16'b0, instr[15:0]} : signImm;

    assign pcAdd4     = pc + 32'd4;
    assign pcAdd8     = pc + 32'd8;  // JAL link value
    assign jumpAddr   = {pcAdd4[31:28], instr[25:0], 2'b00};
    assign branchAddr = pcAdd4 + {signImm[29:0], 2'b00};

    assign jSuccess   = (predTarget == jumpAddr);
    assign pc8Success = (predTarget == pcAdd8);

endmodule

/* verilog/loadUseHazard.sv */
// ======================================
// loadUseHazard
// load-use stall per load-producing stage
// ======================================
module loadUseHazard import decodePkg::*; (
    input  regIdx        rs,
    input  regIdx        rt,
    input  logic         readsRs,
    input  logic         readsRt,
    resultBus.haz        res,
    output logic         exStall,
    output logic         mem1Stall,
    output logic         mem2Stall
);

    // pending load whose target this instruction really reads
    function automatic logic loadHit(input logic memRead, input regIdx ldDst);
        return memRead && ldDst != '0 &&
               ((readsRs && ldDst == rs) || (readsRt && ldDst == rt));
    endfunction

    always_comb begin
        exStall   = loadHit(res.exeMemRead, res.exeDst);
        mem1Stall = loadHit(res.memMemRead, res.memDst);
        mem2Stall = loadHit(res.mem2MemRead, res.mem2Dst);
    end

endmodule

/* verilog/operandBypass.sv */
// ======================================
// operandBypass
// forwards newer stage results into the
// rs and rt operands
// ======================================
module operandBypass import decodePkg::*; (
    input  regIdx        rs,
    input  regIdx        rt,
    input  word          rfA,
    input  word          rfB,
    resultBus.fwd        res,
    output word          opA,
    output word          opB
);

    fwdSel selA, selB;

    // youngest producer first
    function automatic fwdSel pickSrc(input regIdx r);
        if (r == '0)
            return FWD_RF;  // $0 never forwarded
        if (res.exeRegWrite && res.exeDst == r)
            return FWD_EXE;
        if (res.memRegWrite && res.memDst == r)
            return FWD_MEM;
        if (res.mem2RegWrite && res.mem2Dst == r)
            return FWD_MEM2;
        if (res.wbRegWrite && res.wbDst == r)
            return FWD_WB;
        return FWD_RF;
    endfunction

    function automatic word pickData(input fwdSel sel, input word rfVal);
        case (sel)
            FWD_EXE:  return res.exeResult;
            FWD_MEM:  return res.memResult;
            FWD_MEM2: return res.mem2Result;
            FWD_WB:   return res.wbResult;
            default:  return rfVal;
        endcase
    endfunction

    always_comb begin
        selA = pickSrc(rs);
        selB = pickSrc(rt);
        opA  = pickData(selA, rfA);
        opB  = pickData(selB, rfB);
    end

endmodule

/* verilog/regFile.sv */
// ======================================
// regFile
// 32 x 32 GPRs, one WB write port and
// two async read ports, $0 reads zero
// ======================================
module regFile import decodePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  wrEn,
    input  regIdx wrDst,
    input  word   wrData,
    input  regIdx rs,
    input  regIdx rt,
    output word   busA,
    output word   busB
);

    word regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrDst != '0) begin
            regs[wrDst] <= wrData;
        end
    end

    // no internal write-through, the same-cycle value comes via the WB bypass
    assign busA = (rs == '0) ? '0 : regs[rs];
    assign busB = (rt == '0) ? '0 : regs[rt];

endmodule

/* verilog/resultBus.sv */
// ======================================
// resultBus
// results of EXE, MEM, MEM2 and WB heading
// back to the decode stage
// ======================================
interface resultBus import decodePkg::*; ();

    logic  exeRegWrite, memRegWrite, mem2RegWrite, wbRegWrite;
    regIdx exeDst, memDst, mem2Dst, wbDst;
    word   exeResult, memResult, mem2Result, wbResult;
    logic  exeMemRead, memMemRead, mem2MemRead;  // load pending in that stage

    modport src (
        output exeRegWrite, memRegWrite, mem2RegWrite, wbRegWrite,
        output exeDst, memDst, mem2Dst, wbDst,
        output exeResult, memResult, mem2Result, wbResult,
        output exeMemRead, memMemRead, mem2MemRead
    );

    modport fwd (
        input exeRegWrite, memRegWrite, mem2RegWrite, wbRegWrite,
        input exeDst, memDst, mem2Dst, wbDst,
        input exeResult, memResult, mem2Result, wbResult
    );

    modport haz (input exeDst, memDst, mem2Dst, exeMemRead, memMemRead, mem2MemRead);

endinterface
